//--- source/fv_pkg.sv
// feature value bank shared definitions
// line and node geometry, bus structs and controller states
`default_nettype none

package fv_pkg;

    localparam int FV_WIDTH       = 64;   // two feature values per line
    localparam int LINES_PER_NODE = 8;
    localparam int NODE_ID_W      = 5;
    localparam int ADDR_W         = 8;
    localparam int FV_NUM_W       = 5;    // 0 to 16 features
    localparam int ITER_W         = 2;
    localparam int NODES_PER_ITER = 4;
    localparam int PE_TAG_W       = 2;
    localparam int SM_ADDR_W      = 5;

    localparam int LINE_CNT_W = $clog2(LINES_PER_NODE) + 1;   // holds 0..8
    localparam int NODE_CNT_W = $clog2(NODES_PER_ITER);
    localparam int NODE_SHIFT = $clog2(LINES_PER_NODE);
    localparam int ITER_SHIFT = $clog2(NODES_PER_ITER * LINES_PER_NODE);

    typedef struct packed {
        logic                 valid;
        logic                 rd_wr;      // 1 = write back
        logic [NODE_ID_W-1:0] node_id;
        logic [PE_TAG_W-1:0]  pe_tag;
        logic [FV_WIDTH-1:0]  data;
        logic                 wr_eos;
    } fv_req_t;

    typedef struct packed {
        logic                cen;         // active low
        logic                wen;         // active low
        logic [ADDR_W-1:0]   addr;
        logic [FV_WIDTH-1:0] data;
    } sram_cmd_t;

    typedef struct packed {
        logic                 sos;
        logic                 eos;
        logic [FV_WIDTH-1:0]  data;
        logic [SM_ADDR_W-1:0] addr;
    } sm_stream_t;

    typedef struct packed {
        logic                sos;
        logic                eos;
        logic [FV_WIDTH-1:0] data;
        logic [PE_TAG_W-1:0] pe_tag;
    } edge_rd_t;

    typedef enum logic [1:0] {
        IDLE,
        STREAM_ITER,
        WRITE_BACK,
        READ_TO_EDGE
    } ctrl_state_e;

    // lines per node, values packed in pairs, never less than one
    function automatic logic [LINE_CNT_W-1:0] line_count(input logic [FV_NUM_W-1:0] fv_num);
        logic [FV_NUM_W:0] rounded;
        rounded = ({1'b0, fv_num} + 1'b1) >> 1;
        if (rounded == '0) begin
            rounded = 1;
        end
        return rounded[LINE_CNT_W-1:0];
    endfunction

endpackage

`default_nettype wire

//--- source/fv_req_arbiter.sv
// request arbiter for the feature value bank
// passes write-back lines through, parks one edge read until the controller is idle
`timescale 1ns/1ns
`default_nettype none

module fv_req_arbiter (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          wb_valid,
    input  wire logic [fv_pkg::NODE_ID_W-1:0]  wb_node_id,
    input  wire logic [fv_pkg::FV_WIDTH-1:0]   wb_data,
    input  wire logic                          wb_eos,
    input  wire logic                          rd_valid,
    input  wire logic [fv_pkg::NODE_ID_W-1:0]  rd_node_id,
    input  wire logic [fv_pkg::PE_TAG_W-1:0]   rd_pe_tag,
    input  wire logic                          busy,
    output fv_pkg::fv_req_t                    req
);

    logic                         pend_valid;
    logic [fv_pkg::NODE_ID_W-1:0] pend_node;
    logic [fv_pkg::PE_TAG_W-1:0]  pend_tag;
    logic                         rd_release;

    // writes win over a parked read
    assign rd_release = pend_valid && !busy && !wb_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else if (rd_valid) begin
            pend_valid <= 1'b1;
        end else if (rd_release) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            pend_node <= rd_node_id;
            pend_tag  <= rd_pe_tag;
        end
    end

    always_comb begin
        req.valid   = wb_valid || rd_release;
        req.rd_wr   = wb_valid;
        req.node_id = wb_valid ? wb_node_id : pend_node;
        req.pe_tag  = pend_tag;
        req.data    = wb_data;
        req.wr_eos  = wb_valid && wb_eos;
    end

    // only one read may wait; a second one has to meet a free slot
    a_slot_overflow: assert property (
        @(posedge clk) disable iff (reset)
        (rd_valid && pend_valid) |-> rd_release
    ) else $error("edge read arrived while pending slot full");

endmodule

`default_nettype wire

//--- source/fv_bank_ctrl.sv
// big feature value bank controller
// write-back, edge PE read-back and per-iteration streaming into the small bank
`timescale 1ns/1ns
`default_nettype none

module fv_bank_ctrl (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic [fv_pkg::ITER_W-1:0]    replay_iter,
    input  wire logic                         update_phase,
    input  wire logic [fv_pkg::FV_NUM_W-1:0]  fv_num,
    input  wire fv_pkg::fv_req_t              req,
    input  wire logic [fv_pkg::FV_WIDTH-1:0]  sram_rdata,
    output fv_pkg::sram_cmd_t                 sram_cmd,
    output fv_pkg::sm_stream_t                sm_out,
    output fv_pkg::edge_rd_t                  edge_out,
    output logic                              busy
);

    fv_pkg::ctrl_state_e state, nx_state;

    logic [fv_pkg::LINE_CNT_W-1:0] cnt, nx_cnt;
    logic [fv_pkg::NODE_CNT_W-1:0] node_cnt, nx_node_cnt;
    logic [fv_pkg::ITER_W-1:0]     cur_iter, nx_iter;
    logic                          streamed, nx_streamed;
    logic [fv_pkg::FV_NUM_W-1:0]   fv_num_q, nx_fv_num;
    logic [fv_pkg::PE_TAG_W-1:0]   pe_tag, nx_pe_tag;
    logic [fv_pkg::ADDR_W-1:0]     node_base, nx_node_base;

    logic [fv_pkg::LINE_CNT_W-1:0] lines_in, lines_m1;
    logic [fv_pkg::ADDR_W-1:0]     req_base, iter_base, node_off;
    logic                          stream_go;

    // launch flags, lined up with the read data one cycle later
    logic                         rd_issue, rd_first, rd_last;
    logic                         st_issue, st_first, st_last;
    logic [fv_pkg::SM_ADDR_W-1:0] st_sm_addr;
    logic                         rd_vld_q, rd_sos_q, rd_eos_q;
    logic                         st_vld_q, st_sos_q, st_eos_q;
    logic [fv_pkg::SM_ADDR_W-1:0] st_addr_q;

    assign lines_in  = fv_pkg::line_count(fv_num);
    assign lines_m1  = fv_pkg::line_count(fv_num_q) - 1'b1;
    assign req_base  = fv_pkg::ADDR_W'(req.node_id) << fv_pkg::NODE_SHIFT;
    assign iter_base = fv_pkg::ADDR_W'(cur_iter) << fv_pkg::ITER_SHIFT;
    assign node_off  = fv_pkg::ADDR_W'(node_cnt) << fv_pkg::NODE_SHIFT;

    assign stream_go = (state == fv_pkg::IDLE) && update_phase
                       && (!streamed || (replay_iter != cur_iter));

    always_comb begin
        sram_cmd.cen  = 1'b1;
        sram_cmd.wen  = 1'b1;
        sram_cmd.addr = '0;
        sram_cmd.data = '0;
        nx_state     = state;
        nx_cnt       = cnt;
        nx_node_cnt  = node_cnt;
        nx_iter      = cur_iter;
        nx_streamed  = streamed;
        nx_fv_num    = fv_num_q;
        nx_pe_tag    = pe_tag;
        nx_node_base = node_base;
        rd_issue = 1'b0;
        rd_first = 1'b0;
        rd_last  = 1'b0;
        st_issue = 1'b0;
        st_first = 1'b0;
        st_last  = 1'b0;
        st_sm_addr = fv_pkg::SM_ADDR_W'({node_cnt, cnt[fv_pkg::NODE_SHIFT-1:0]});

        case (state)
            fv_pkg::IDLE: begin
                if (stream_go) begin   // line 0 of node 0 goes out right away
                    nx_state    = fv_pkg::STREAM_ITER;
                    nx_iter     = replay_iter;
                    nx_streamed = 1'b1;
                    nx_fv_num   = fv_num;
                    sram_cmd.cen  = 1'b0;
                    sram_cmd.addr = fv_pkg::ADDR_W'(replay_iter) << fv_pkg::ITER_SHIFT;
                    st_issue   = 1'b1;
                    st_first   = 1'b1;
                    st_sm_addr = '0;
                    if (lines_in == 1) begin
                        nx_node_cnt = 1;
                    end else begin
                        nx_cnt = 1;
                    end
                end else if (req.valid && req.rd_wr) begin
                    sram_cmd.cen  = 1'b0;
                    sram_cmd.wen  = 1'b0;
                    sram_cmd.addr = req_base;
                    sram_cmd.data = req.data;
                    nx_node_base  = req_base;
                    if (!req.wr_eos) begin
                        nx_state = fv_pkg::WRITE_BACK;
                        nx_cnt   = 1;
                    end
                end else if (req.valid) begin
                    sram_cmd.cen  = 1'b0;
                    sram_cmd.addr = req_base;
                    rd_issue     = 1'b1;
                    rd_first     = 1'b1;
                    rd_last      = (lines_in == 1);
                    nx_fv_num    = fv_num;
                    nx_pe_tag    = req.pe_tag;
                    nx_node_base = req_base;
                    if (lines_in != 1) begin
                        nx_state = fv_pkg::READ_TO_EDGE;
                        nx_cnt   = 1;
                    end
                end
            end
            fv_pkg::STREAM_ITER: begin
                sram_cmd.cen  = 1'b0;
                sram_cmd.addr = iter_base + node_off + fv_pkg::ADDR_W'(cnt);
                st_issue = 1'b1;
                if (cnt == lines_m1) begin
                    nx_cnt      = '0;
                    nx_node_cnt = node_cnt + 1'b1;
                    if (node_cnt == fv_pkg::NODE_CNT_W'(fv_pkg::NODES_PER_ITER - 1)) begin
                        st_last  = 1'b1;
                        nx_state = fv_pkg::IDLE;
                    end
                end else begin
                    nx_cnt = cnt + 1'b1;
                end
            end
            fv_pkg::WRITE_BACK: begin
                if (req.valid && req.rd_wr) begin
                    sram_cmd.cen  = 1'b0;
                    sram_cmd.wen  = 1'b0;
                    sram_cmd.addr = node_base + fv_pkg::ADDR_W'(cnt);
                    sram_cmd.data = req.data;
                    nx_cnt = cnt + 1'b1;
                    if (req.wr_eos) begin
                        nx_state = fv_pkg::IDLE;
                        nx_cnt   = '0;
                    end
                end
            end
            fv_pkg::READ_TO_EDGE: begin
                sram_cmd.cen  = 1'b0;
                sram_cmd.addr = node_base + fv_pkg::ADDR_W'(cnt);
                rd_issue = 1'b1;
                if (cnt == lines_m1) begin
                    rd_last  = 1'b1;
                    nx_state = fv_pkg::IDLE;
                    nx_cnt   = '0;
                end else begin
                    nx_cnt = cnt + 1'b1;
                end
            end
            default: nx_state = fv_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= fv_pkg::IDLE;
            cnt      <= '0;
            node_cnt <= '0;
            cur_iter <= '0;
            streamed <= 1'b0;
            rd_vld_q <= 1'b0;
            rd_sos_q <= 1'b0;
            rd_eos_q <= 1'b0;
            st_vld_q <= 1'b0;
            st_sos_q <= 1'b0;
            st_eos_q <= 1'b0;
        end else begin
            state    <= nx_state;
            cnt      <= nx_cnt;
            node_cnt <= nx_node_cnt;
            cur_iter <= nx_iter;
            streamed <= nx_streamed;
            rd_vld_q <= rd_issue;
            rd_sos_q <= rd_first;
            rd_eos_q <= rd_last;
            st_vld_q <= st_issue;
            st_sos_q <= st_first;
            st_eos_q <= st_last;
        end
    end

    always_ff @(posedge clk) begin
        fv_num_q  <= nx_fv_num;
        pe_tag    <= nx_pe_tag;
        node_base <= nx_node_base;
        st_addr_q <= st_sm_addr;
    end

    always_comb begin
        sm_out.sos  = st_sos_q;
        sm_out.eos  = st_eos_q;
        sm_out.data = st_vld_q ? sram_rdata : '0;
        sm_out.addr = st_addr_q;
        edge_out.sos    = rd_sos_q;
        edge_out.eos    = rd_eos_q;
        edge_out.data   = rd_vld_q ? sram_rdata : '0;
        edge_out.pe_tag = rd_vld_q ? pe_tag : '0;
    end

    assign busy = (state != fv_pkg::IDLE) || stream_go || rd_vld_q || st_vld_q;

    a_sm_sos: assert property (@(posedge clk) disable iff (reset)
        sm_out.sos |-> $past(state) == fv_pkg::IDLE
    ) else $error("small bank sos outside stream launch");

    a_sm_eos: assert property (@(posedge clk) disable iff (reset)
        sm_out.eos |-> $past(state) == fv_pkg::STREAM_ITER
    ) else $error("small bank eos outside streaming");

    a_edge_frame: assert property (@(posedge clk) disable iff (reset)
        (edge_out.sos || edge_out.eos)
            |-> $past(state) inside {fv_pkg::IDLE, fv_pkg::READ_TO_EDGE}
    ) else $error("edge sos/eos outside read");

    // a write-back line here would never reach the SRAM
    a_no_wr_stream: assert property (@(posedge clk) disable iff (reset)
        (stream_go || state == fv_pkg::STREAM_ITER) |-> !(req.valid && req.rd_wr)
    ) else $error("write-back request during streaming");

endmodule

`default_nettype wire

//--- source/fv_sram_bank.sv
// single-port feature value SRAM, 256 x 64
// active-low enables, one cycle read latency
`timescale 1ns/1ns
`default_nettype none

module fv_sram_bank (
    input  wire logic                        clk,
    input  wire fv_pkg::sram_cmd_t           cmd,
    output logic [fv_pkg::FV_WIDTH-1:0]      rdata
);

    localparam int DEPTH = 2 ** fv_pkg::ADDR_W;

    logic [fv_pkg::FV_WIDTH-1:0] mem [DEPTH];

    logic wr_en;
    logic rd_en;

    assign wr_en = !cmd.cen && !cmd.wen;
    assign rd_en = !cmd.cen && cmd.wen;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[cmd.addr] <= cmd.data;
        end
    end

    // output holds its last value between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[cmd.addr];
        end
    end

endmodule

`default_nettype wire

//--- source/fv_small_bank.sv
// small feature value bank
// captures one streamed iteration block, combinational read port
`timescale 1ns/1ns
`default_nettype none

module fv_small_bank (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire fv_pkg::sm_stream_t            sm_in,
    input  wire logic [fv_pkg::SM_ADDR_W-1:0]  rd_addr,
    output logic [fv_pkg::FV_WIDTH-1:0]        rd_data
);

    localparam int DEPTH = 2 ** fv_pkg::SM_ADDR_W;

    logic [fv_pkg::FV_WIDTH-1:0] mem [DEPTH];

    logic in_frame;
    logic wr_en;

    // stream has no gaps, so the frame window is the write enable
    assign wr_en = sm_in.sos || in_frame;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_frame <= 1'b0;
        end else if (sm_in.eos) begin
            in_frame <= 1'b0;
        end else if (sm_in.sos) begin
            in_frame <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[sm_in.addr] <= sm_in.data;
        end
    end

    assign rd_data = mem[rd_addr];

    a_sos_in_frame: assert property (@(posedge clk) disable iff (reset)
        sm_in.sos |-> !in_frame
    ) else $error("sos while small bank frame open");

endmodule

`default_nettype wire

//--- source/fv_bank_top.sv
// feature value bank top level
// arbiter, controller, SRAM bank and small bank
`timescale 1ns/1ns
`default_nettype none

module fv_bank_top (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic [fv_pkg::ITER_W-1:0]     replay_iter,
    input  wire logic                          update_phase,
    input  wire logic [fv_pkg::FV_NUM_W-1:0]   fv_num,
    input  wire logic                          wb_valid,
    input  wire logic [fv_pkg::NODE_ID_W-1:0]  wb_node_id,
    input  wire logic [fv_pkg::FV_WIDTH-1:0]   wb_data,
    input  wire logic                          wb_eos,
    input  wire logic                          rd_valid,
    input  wire logic [fv_pkg::NODE_ID_W-1:0]  rd_node_id,
    input  wire logic [fv_pkg::PE_TAG_W-1:0]   rd_pe_tag,
    output fv_pkg::edge_rd_t                   edge_out,
    output logic                               busy,
    input  wire logic [fv_pkg::SM_ADDR_W-1:0]  sm_rd_addr,
    output logic [fv_pkg::FV_WIDTH-1:0]        sm_rd_data
);

    fv_pkg::fv_req_t             req;
    fv_pkg::sram_cmd_t           sram_cmd;
    logic [fv_pkg::FV_WIDTH-1:0] sram_rdata;
    fv_pkg::sm_stream_t          sm_stream;

    fv_req_arbiter u_arb (
        .clk, .reset,
        .wb_valid, .wb_node_id, .wb_data, .wb_eos,
        .rd_valid, .rd_node_id, .rd_pe_tag,
        .busy,
        .req
    );

    fv_bank_ctrl u_ctrl (
        .clk, .reset,
        .replay_iter, .update_phase, .fv_num,
        .req,
        .sram_rdata,
        .sram_cmd,
        .sm_out   (sm_stream),
        .edge_out,
        .busy
    );

    fv_sram_bank u_sram (.clk, .cmd(sram_cmd), .rdata(sram_rdata));

    fv_small_bank u_small (
        .clk, .reset,
        .sm_in   (sm_stream),
        .rd_addr (sm_rd_addr),
        .rd_data (sm_rd_data)
    );

endmodule

`default_nettype wire

//--- sim/fv_clk_gen.sv
// testbench clock and reset
// 8 ns clock, reset held for the first 16 cycles
`timescale 1ns/1ns
`default_nettype none

module fv_clk_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;   // released just after an edge, like the stimulus
    end

endmodule

`default_nettype wire

//--- sim/fv_bank_model.svh
// reference model for the feature value bank testbench
// model memory, expected stream builders and value checks
`ifndef FV_BANK_MODEL_SVH
`define FV_BANK_MODEL_SVH
`default_nettype none

logic [fv_pkg::FV_WIDTH-1:0] model_mem [2 ** fv_pkg::ADDR_W];
int                          wr_len [2 ** fv_pkg::NODE_ID_W];   // longest burst seen per node
logic [fv_pkg::FV_WIDTH-1:0] exp_q [$];
int                          exp_addr_q [$];
int                          check_cnt = 0;
int                          err_cnt = 0;

// two values per line, rounded up, at least one line
function automatic int lines_for(input int fvn);
    int n;
    n = (fvn + 1) / 2;
    if (n < 1) begin
        n = 1;
    end
    return n;
endfunction

task automatic store_line(input int node, input int line, input logic [63:0] d);
    model_mem[node * fv_pkg::LINES_PER_NODE + line] = d;
endtask

task automatic build_edge_exp(input int node, input int fvn);
    exp_q.delete();
    for (int ln = 0; ln < lines_for(fvn); ln++) begin
        exp_q.push_back(model_mem[node * fv_pkg::LINES_PER_NODE + ln]);
    end
endtask

// small bank image of one iteration block
task automatic build_stream_exp(input int iter, input int fvn);
    int node;
    exp_q.delete();
    exp_addr_q.delete();
    for (int slot = 0; slot < fv_pkg::NODES_PER_ITER; slot++) begin
        node = iter * fv_pkg::NODES_PER_ITER + slot;
        for (int ln = 0; ln < lines_for(fvn); ln++) begin
            exp_addr_q.push_back(slot * fv_pkg::LINES_PER_NODE + ln);
            exp_q.push_back(model_mem[node * fv_pkg::LINES_PER_NODE + ln]);
        end
    end
endtask

task automatic check_val(input string name, input logic [63:0] exp_v, input logic [63:0] got);
    check_cnt++;
    assert (got === exp_v) else begin
        $display("Fail t=%0t %s expected %h got %h", $time, name, exp_v, got);
        err_cnt++;
    end
endtask

task automatic note_timeout(input string what);
    $display("timeout at t=%0t: %s", $time, what);
    err_cnt++;
endtask

`default_nettype wire
`endif

//--- sim/fv_bank_tb.sv
// feature value bank testbench
// random write-back, edge reads and iteration streaming against a model memory
`timescale 1ns/1ns
`default_nettype none

module fv_bank_tb;

    localparam int TIMEOUT = 200;

    logic                          clk;
    logic                          reset;
    logic [fv_pkg::ITER_W-1:0]     replay_iter;
    logic                          update_phase;
    logic [fv_pkg::FV_NUM_W-1:0]   fv_num;
    logic                          wb_valid;
    logic [fv_pkg::NODE_ID_W-1:0]  wb_node_id;
    logic [fv_pkg::FV_WIDTH-1:0]   wb_data;
    logic                          wb_eos;
    logic                          rd_valid;
    logic [fv_pkg::NODE_ID_W-1:0]  rd_node_id;
    logic [fv_pkg::PE_TAG_W-1:0]   rd_pe_tag;
    fv_pkg::edge_rd_t              edge_out;
    logic                          busy;
    logic [fv_pkg::SM_ADDR_W-1:0]  sm_rd_addr;
    logic [fv_pkg::FV_WIDTH-1:0]   sm_rd_data;

    integer seed = 32'h3979ac5c;
    int     test_err_base = 0;
    int     written_q [$];   // nodes with at least one line stored

    `include "fv_bank_model.svh"

    fv_clk_gen u_clk (.clk, .reset);

    fv_bank_top u_dut (
        .clk, .reset, .replay_iter, .update_phase, .fv_num,
        .wb_valid, .wb_node_id, .wb_data, .wb_eos,
        .rd_valid, .rd_node_id, .rd_pe_tag,
        .edge_out, .busy, .sm_rd_addr, .sm_rd_data
    );

    function automatic int pick(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + r % (hi - lo + 1);
    endfunction

    function automatic logic [63:0] rand_line();
        return {$random(seed), $random(seed)};
    endfunction

    // samples busy at falling edges, returns in the drive slot after a rising edge
    task automatic wait_busy(input logic level, input string what);
        int cyc;
        cyc = 0;
        @(negedge clk);
        while (busy !== level && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (busy !== level) begin
            note_timeout(what);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic write_burst(input int node, input int len);
        logic [63:0] d;
        wait_busy(1'b0, "busy stuck high before write burst");
        if (wr_len[node] == 0) begin
            written_q.push_back(node);
        end
        for (int k = 0; k < len; k++) begin
            d = rand_line();
            wb_valid   = 1'b1;
            wb_node_id = fv_pkg::NODE_ID_W'(node);
            wb_data    = d;
            wb_eos     = (k == len - 1);
            store_line(node, k, d);
            @(posedge clk);
            #1;
        end
        wb_valid = 1'b0;
        wb_eos   = 1'b0;
        if (len > wr_len[node]) begin
            wr_len[node] = len;
        end
    endtask

    task automatic fill_iter(input int iter);
        for (int slot = 0; slot < fv_pkg::NODES_PER_ITER; slot++) begin
            write_burst(iter * fv_pkg::NODES_PER_ITER + slot, fv_pkg::LINES_PER_NODE);
        end
    endtask

    // first data two cycles after the read, or after every line of a stream ahead of it
    task automatic edge_read(input int node, input int tag, input int fvn,
                             input int stream_lines);
        int cyc;
        if (stream_lines == 0) begin
            wait_busy(1'b0, "busy stuck high before edge read");
        end
        build_edge_exp(node, fvn);
        fv_num     = fv_pkg::FV_NUM_W'(fvn);
        rd_valid   = 1'b1;
        rd_node_id = fv_pkg::NODE_ID_W'(node);
        rd_pe_tag  = fv_pkg::PE_TAG_W'(tag);
        @(posedge clk);
        #1;
        rd_valid = 1'b0;
        @(negedge clk);
        cyc = 1;
        while (edge_out.sos !== 1'b1 && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (edge_out.sos !== 1'b1) begin
            note_timeout("edge read never raised sos");
        end else begin
            check_val("edge read latency", stream_lines + 2, cyc);
            for (int k = 0; k < exp_q.size(); k++) begin
                if (k > 0) begin
                    @(negedge clk);
                end
                check_val("edge_out.data", exp_q[k], edge_out.data);
                check_val("edge_out.pe_tag", tag, edge_out.pe_tag);
                check_val("edge_out.sos", k == 0, edge_out.sos);
                check_val("edge_out.eos", k == exp_q.size() - 1, edge_out.eos);
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_stream(input int iter);
        replay_iter  = fv_pkg::ITER_W'(iter);
        update_phase = 1'b1;
        wait_busy(1'b1, "stream did not start");
        wait_busy(1'b0, "stream did not finish");
    endtask

    task automatic check_small(input int iter, input int fvn);
        build_stream_exp(iter, fvn);
        foreach (exp_q[i]) begin
            sm_rd_addr = fv_pkg::SM_ADDR_W'(exp_addr_q[i]);
            @(negedge clk);
            check_val("sm_rd_data", exp_q[i], sm_rd_data);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_err_base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    initial begin
        int node;
        int iter_a;
        int iter_b;
        int fvn;
        int cyc;
        replay_iter  = '0;
        update_phase = 1'b0;
        fv_num       = 5'd16;
        wb_valid     = 1'b0;
        wb_node_id   = '0;
        wb_data      = '0;
        wb_eos       = 1'b0;
        rd_valid     = 1'b0;
        rd_node_id   = '0;
        rd_pe_tag    = '0;
        sm_rd_addr   = '0;

        cyc = 0;
        while (reset !== 1'b0 && cyc < 64) begin
            @(posedge clk);
            cyc++;
        end
        if (reset !== 1'b0) begin
            note_timeout("reset never released");
        end
        #1;

        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_val("busy", 0, busy);
            check_val("edge_out.sos", 0, edge_out.sos);
            check_val("edge_out.eos", 0, edge_out.eos);
            check_val("sm_stream.sos", 0, u_dut.sm_stream.sos);
            check_val("sm_stream.eos", 0, u_dut.sm_stream.eos);
            @(posedge clk);
            #1;
        end
        end_test("idle after reset");

        for (int i = 0; i < 12; i++) begin
            write_burst(pick(0, 31), pick(1, 8));
        end
        for (int i = 0; i < 16; i++) begin
            node = written_q[pick(0, written_q.size() - 1)];
            edge_read(node, pick(0, 3), pick(1, 2 * wr_len[node]), 0);   // odd counts too
        end
        end_test("write-back and edge read");

        iter_a = pick(0, 3);
        fill_iter(iter_a);
        fvn    = pick(1, 16);
        fv_num = fv_pkg::FV_NUM_W'(fvn);
        run_stream(iter_a);
        check_small(iter_a, fvn);
        end_test("iteration stream");

        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            check_val("busy", 0, busy);
            @(posedge clk);
            #1;
        end
        check_small(iter_a, fvn);
        end_test("same iteration held");

        iter_b = (iter_a + 1) % 4;
        fill_iter(iter_b);
        fvn    = pick(1, 16);
        fv_num = fv_pkg::FV_NUM_W'(fvn);
        replay_iter = fv_pkg::ITER_W'(iter_b);   // stream launches this cycle
        node = iter_b * fv_pkg::NODES_PER_ITER + pick(0, 3);
        edge_read(node, pick(0, 3), fvn, fv_pkg::NODES_PER_ITER * lines_for(fvn));
        wait_busy(1'b0, "busy stuck high after held read");
        check_small(iter_b, fvn);
        end_test("read held during stream");

        node = pick(0, 31);
        write_burst(node, fv_pkg::LINES_PER_NODE);
        write_burst(node, fv_pkg::LINES_PER_NODE);
        edge_read(node, pick(0, 3), 16, 0);
        end_test("overwrite");

        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fv_bank.f
+incdir+sim
source/fv_pkg.sv
source/fv_req_arbiter.sv
source/fv_bank_ctrl.sv
source/fv_sram_bank.sv
source/fv_small_bank.sv
source/fv_bank_top.sv
sim/fv_clk_gen.sv
sim/fv_bank_tb.sv

//--- Makefile
VERILATOR  = verilator
VFLAGS     = --timing --assert
SIM_FLAGS  = --binary -j 0 --Wno-fatal
TOP        = fv_bank_tb
FILELIST   = fv_bank.f
OBJ_DIR    = obj_dir
PASS_TEXT  = sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
